/* src.f */
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_tag_store.sv
dcache_lru.sv
dcache_data_store.sv
dcache_line_xfer.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_geom_pkg.sv
  - dcache_bus_pkg.sv
  - dcache_tag_store.sv
  - dcache_lru.sv
  - dcache_data_store.sv
  - dcache_line_xfer.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv

/* tb_dcache.sv */
`default_nettype none

module tb_dcache;

  localparam int clk_period = 40;
  localparam int n_tests    = 5;
  localparam int ok_limit   = 600; // Cycles allowed for one access

  logic        clk;
  logic        rst;
  logic        req;
  logic [31:0] addr;
  logic        wreq;
  logic [3:0]  wbyte;
  logic [31:0] din;
  logic [31:0] ins;
  logic        ok;
  logic        miss;
  logic        wen;
  logic [31:0] waddr;
  logic [31:0] wdata;
  logic        wdata_ok;
  logic        sen;
  logic [31:0] raddr;
  logic        rdata_ok;
  logic [31:0] sdata;

  // Memory model and the architectural view of memory
  logic [31:0] mem_model [2048];
  logic [31:0] exp_mem   [2048];

  // Shadow cache state
  logic [21:0] sh_tag   [16][4];
  logic        sh_valid [16][4];
  logic        sh_dirty [16][4];
  logic [1:0]  sh_age   [16][4];

  logic [31:0] rng;
  logic        in_access;
  logic        exp_wb;
  logic [31:0] exp_wb_base;
  logic [31:0] exp_rf_base;
  logic [3:0]  wb_cnt;
  logic [3:0]  rf_cnt;
  int          wb_beats;
  int          rf_beats;
  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;

  dcache_top u_dut (
    .clk(clk), .rst(rst), .req(req), .addr(addr), .wreq(wreq), .wbyte(wbyte), .din(din),
    .ins(ins), .ok(ok), .miss(miss), .wen(wen), .waddr(waddr), .wdata(wdata),
    .wdata_ok(wdata_ok), .sen(sen), .raddr(raddr), .rdata_ok(rdata_ok), .sdata(sdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Fill pattern over the full word address
  function automatic logic [31:0] init_word(input logic [31:0] i);
    return (i * 32'h9e3779b1) ^ {i[15:0], ~i[15:0]};
  endfunction

  function automatic logic [31:0] line_addr(input logic [21:0] tag, input logic [3:0] set,
                                            input logic [3:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  task automatic log_error(input string msg);
    err_count++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic int shadow_hit_way(input logic [3:0] set, input logic [21:0] tag);
    for (int w = 0; w < 4; w++)
      if (sh_valid[set][w] && sh_tag[set][w] == tag)
        return w;
    return -1;
  endfunction

  function automatic int shadow_victim(input logic [3:0] set);
    for (int w = 0; w < 4; w++)
      if (!sh_valid[set][w])
        return w;
    for (int w = 0; w < 4; w++)
      if (sh_age[set][w] == 2'd3)
        return w;
    return 0;
  endfunction

  task automatic shadow_touch(input logic [3:0] set, input int tw);
    for (int w = 0; w < 4; w++)
      if (w != tw && sh_age[set][w] < sh_age[set][tw])
        sh_age[set][w] = sh_age[set][w] + 2'd1;
    sh_age[set][tw] = 2'd0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count != test_err_start)
      tests_failed++;
    $display("test %0d %-22s %s", tests_run, name,
             (err_count == test_err_start) ? "passed" : "had errors");
    test_err_start = err_count;
  endtask

  //////////////////////////////////////////////////
  // One CPU request, checked against the shadow model

  task automatic access(input logic [31:0] a, input logic w, input logic [3:0] be,
                        input logic [31:0] d);
    logic [3:0]  set;
    logic [21:0] tag;
    logic [10:0] wi;
    logic [31:0] expect_val;
    logic        pred_hit;
    int          way;
    int          cycles;
    set        = a[9:6];
    tag        = a[31:10];
    wi         = a[12:2];
    way        = shadow_hit_way(set, tag);
    pred_hit   = (way >= 0);
    exp_wb     = 1'b0;
    if (!pred_hit)
    begin
      way         = shadow_victim(set);
      exp_wb      = sh_valid[set][way] && sh_dirty[set][way];
      exp_wb_base = {sh_tag[set][way], set, 6'd0};
    end
    exp_rf_base = {tag, set, 6'd0};
    expect_val  = w ? d : exp_mem[wi];
    wb_beats    = 0;
    rf_beats    = 0;
    wb_cnt      = '0;
    rf_cnt      = '0;
    in_access   = 1'b1;
    @(negedge clk);
    req   = 1'b1;
    addr  = a;
    wreq  = w;
    wbyte = be;
    din   = d;
    @(negedge clk);
    req = 1'b0;
    // Lookup cycle
    assert (miss == !pred_hit)
      else log_error($sformatf("miss=%b for %h, expected %b", miss, a, !pred_hit));
    if (pred_hit)
    begin
      assert (ok) else log_error($sformatf("hit on %h gave no ok one cycle after req", a));
    end
    cycles = 0;
    while (!ok && cycles < ok_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!ok)
    begin
      err_count++;
      $display("Access to %h got no ok within %0d cycles", a, ok_limit);
    end
    else
    begin
      assert (ins == expect_val)
        else log_error($sformatf("ins %h for %h, expected %h", ins, a, expect_val));
      assert (rf_beats == (pred_hit ? 0 : 16))
        else log_error($sformatf("%0d refill beats for %h", rf_beats, a));
      assert (wb_beats == (exp_wb ? 16 : 0))
        else log_error($sformatf("%0d writeback beats for %h", wb_beats, a));
    end
    in_access = 1'b0;
    exp_wb    = 1'b0;
    if (!pred_hit)
    begin
      sh_valid[set][way] = 1'b1;
      sh_tag[set][way]   = tag;
      sh_dirty[set][way] = 1'b0;
    end
    if (w)
    begin
      sh_dirty[set][way] = 1'b1;
      for (int b = 0; b < 4; b++)
        if (be[b])
          exp_mem[wi][8*b +: 8] = d[8*b +: 8];
    end
    shadow_touch(set, way);
  endtask

  //////////////////////////////////////////////////
  // Memory model

  always @(negedge clk)
  begin
    rng      = lcg_next(rng);
    rdata_ok = (rng[31:30] != 2'b00); // Stall one beat in four
    wdata_ok = (rng[29:28] != 2'b00);
    sdata    = mem_model[{raddr[12:6], rf_cnt}];
  end

  always @(posedge clk)
  begin
    if (!rst && sen && rdata_ok)
    begin
      assert (in_access) else log_error("refill beat with no request pending");
      assert (raddr == exp_rf_base)
        else log_error($sformatf("raddr %h, expected %h", raddr, exp_rf_base));
      assert (!exp_wb || wb_beats == 16)
        else log_error("refill started before the writeback finished");
      rf_cnt = rf_cnt + 4'd1;
      rf_beats++;
    end
    if (!rst && wen && wdata_ok)
    begin
      assert (exp_wb) else log_error($sformatf("unexpected writeback to %h", waddr));
      assert (waddr == exp_wb_base)
        else log_error($sformatf("waddr %h, expected %h", waddr, exp_wb_base));
      assert (wdata == exp_mem[{waddr[12:6], wb_cnt}])
        else log_error($sformatf("wdata %h on beat %0d, expected %h", wdata, wb_cnt,
                                 exp_mem[{waddr[12:6], wb_cnt}]));
      mem_model[{waddr[12:6], wb_cnt}] = wdata;
      wb_cnt = wb_cnt + 4'd1;
      wb_beats++;
    end
  end

  a_quiet_in_reset: assert property (@(negedge clk) rst |-> !(ok || miss || wen || sen))
    else log_error("outputs active during reset");

  a_read_hold: assert property (@(posedge clk) disable iff (rst)
    (sen && !rdata_ok) |=> (sen && $stable(raddr)))
    else log_error("refill request dropped while stalled");

  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    (wen && !wdata_ok) |=> (wen && $stable(waddr) && $stable(wdata)))
    else log_error("writeback beat changed while stalled");

  //////////////////////////////////////////////////
  // Tests

  initial
  begin
    logic [21:0] victim_tag;
    rst            = 1'b1;
    req            = 1'b0;
    addr           = '0;
    wreq           = 1'b0;
    wbyte          = '0;
    din            = '0;
    wdata_ok       = 1'b0;
    rdata_ok       = 1'b0;
    sdata          = '0;
    rng            = 32'h6f7e50b8;
    in_access      = 1'b0;
    exp_wb         = 1'b0;
    exp_wb_base    = '0;
    exp_rf_base    = '0;
    wb_cnt         = '0;
    rf_cnt         = '0;
    wb_beats       = 0;
    rf_beats       = 0;
    err_count      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_start = 0;
    for (int i = 0; i < 2048; i++)
    begin
      mem_model[i] = init_word(32'(i));
      exp_mem[i]   = init_word(32'(i));
    end
    for (int s = 0; s < 16; s++)
      for (int w = 0; w < 4; w++)
      begin
        sh_tag[s][w]   = '0;
        sh_valid[s][w] = 1'b0;
        sh_dirty[s][w] = 1'b0;
        sh_age[s][w]   = 2'(w);
      end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    assert (!ok && !miss && !wen && !sen) else log_error("outputs not idle after reset");
    access(line_addr(22'd1, 4'd2, 4'd5), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd1, 4'd2, 4'd5), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd1, 4'd2, 4'd0), 1'b0, 4'h0, 32'h0);
    end_test("reset and read path");

    access(line_addr(22'd1, 4'd2, 4'd5), 1'b1, 4'b0101, 32'ha1b2c3d4);
    access(line_addr(22'd1, 4'd2, 4'd5), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd1, 4'd2, 4'd6), 1'b1, 4'b1000, 32'h5e000000);
    access(line_addr(22'd1, 4'd2, 4'd6), 1'b0, 4'h0, 32'h0);
    end_test("byte store hit");

    access(line_addr(22'd2, 4'd3, 4'd9), 1'b1, 4'b0011, 32'h0000beef);
    access(line_addr(22'd2, 4'd3, 4'd9), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd2, 4'd3, 4'd0), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd2, 4'd3, 4'd15), 1'b0, 4'h0, 32'h0);
    end_test("write-allocate miss");

    for (int t = 0; t < 4; t++)
      access(line_addr(22'(t), 4'd7, 4'(t)), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd1, 4'd7, 4'd0), 1'b0, 4'h0, 32'h0); // Re-touches
    access(line_addr(22'd0, 4'd7, 4'd0), 1'b0, 4'h0, 32'h0);
    victim_tag = sh_tag[7][shadow_victim(4'd7)];
    access(line_addr(22'd4, 4'd7, 4'd2), 1'b0, 4'h0, 32'h0);
    // Survivors hit, then the predicted victim misses
    for (int t = 0; t < 4; t++)
      if (22'(t) != victim_tag)
        access(line_addr(22'(t), 4'd7, 4'd1), 1'b0, 4'h0, 32'h0);
    access(line_addr(victim_tag, 4'd7, 4'd1), 1'b0, 4'h0, 32'h0);
    end_test("LRU replacement");

    for (int t = 0; t < 4; t++)
      access(line_addr(22'(t), 4'd11, 4'd3), 1'b1, 4'b1111, 32'hc0de0000 + 32'(t));
    access(line_addr(22'd4, 4'd11, 4'd3), 1'b0, 4'h0, 32'h0); // Dirty eviction
    for (int t = 0; t < 5; t++)
      access(line_addr(22'(t), 4'd12, 4'd0), 1'b0, 4'h0, 32'h0); // Clean eviction
    access(line_addr(22'd0, 4'd11, 4'd3), 1'b0, 4'h0, 32'h0);
    access(line_addr(22'd0, 4'd11, 4'd8), 1'b0, 4'h0, 32'h0);
    end_test("dirty writeback");

    $display("tests run: %0d, tests with errors: %0d, errors: %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    #(n_tests * 2000 * clk_period);
    $display("Watchdog expired before the tests finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* dcache_top.sv */
`default_nettype none

module dcache_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               req,
  input  logic [dcache_geom_pkg::addr_w-1:0] addr,
  input  logic                               wreq,
  input  logic [dcache_geom_pkg::be_w-1:0]   wbyte,
  input  logic [dcache_geom_pkg::data_w-1:0] din,
  output logic [dcache_geom_pkg::data_w-1:0] ins,
  output logic                               ok,
  output logic                               miss,
  output logic                               wen,
  output logic [dcache_geom_pkg::addr_w-1:0] waddr,
  output logic [dcache_geom_pkg::data_w-1:0] wdata,
  input  logic                               wdata_ok,
  output logic                               sen,
  output logic [dcache_geom_pkg::addr_w-1:0] raddr,
  input  logic                               rdata_ok,
  input  logic [dcache_geom_pkg::data_w-1:0] sdata
);

  dcache_geom_pkg::cache_addr_t         req_addr;
  logic [dcache_geom_pkg::way_w-1:0]    cur_way, hit_way, victim_way;
  logic                                 hit;
  logic [dcache_geom_pkg::num_ways-1:0] valid_vec, dirty_vec;
  logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::tag_w-1:0] victim_tags;
  logic [dcache_geom_pkg::data_w-1:0]   cpu_rdata, fill_wdata;
  logic [dcache_bus_pkg::beat_cnt_w-1:0] beat;
  logic                                 xfer_done, xfer_start, xfer_is_wb;
  logic                                 cpu_we, fill_we, tag_fill_we, dirty_set, touch;
  logic [dcache_geom_pkg::be_w-1:0]     cpu_be;

  //////////////////////////////////////////////////
  // Storage

  dcache_tag_store u_tags (
    .clk(clk), .rst(rst), .index(req_addr.fld.index), .tag(req_addr.fld.tag),
    .fill_way(cur_way), .fill_we(tag_fill_we), .dirty_way(cur_way), .dirty_set(dirty_set),
    .hit(hit), .hit_way(hit_way), .valid_vec(valid_vec), .dirty_vec(dirty_vec),
    .victim_tags(victim_tags)
  );

  dcache_lru u_lru (
    .clk(clk), .rst(rst), .index(req_addr.fld.index), .valid_vec(valid_vec),
    .touch(touch), .touch_way(cur_way), .victim_way(victim_way)
  );

  // Store data comes back on ins
  dcache_data_store u_data (
    .clk(clk), .index(req_addr.fld.index), .way(cur_way), .word_sel(req_addr.fld.word_sel),
    .cpu_we(cpu_we), .cpu_be(cpu_be), .cpu_wdata(ins),
    .fill_we(fill_we), .fill_word(beat), .fill_wdata(fill_wdata),
    .rd_word(beat), .cpu_rdata(cpu_rdata), .wb_rdata(wdata)
  );

  //////////////////////////////////////////////////
  // Control and memory bursts

  dcache_ctrl u_ctrl (
    .clk(clk), .rst(rst), .req(req), .addr(addr), .wreq(wreq), .wbyte(wbyte), .din(din),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way), .dirty_vec(dirty_vec),
    .victim_tags(victim_tags), .cpu_rdata(cpu_rdata), .sdata(sdata), .beat(beat),
    .xfer_done(xfer_done), .ins(ins), .ok(ok), .miss(miss), .req_addr(req_addr),
    .cur_way(cur_way), .cpu_we(cpu_we), .cpu_be(cpu_be), .fill_we(fill_we),
    .tag_fill_we(tag_fill_we), .dirty_set(dirty_set), .touch(touch),
    .xfer_start(xfer_start), .xfer_is_wb(xfer_is_wb), .waddr(waddr), .raddr(raddr),
    .fill_wdata(fill_wdata)
  );

  dcache_line_xfer u_xfer (
    .clk(clk), .rst(rst), .xfer_start(xfer_start), .xfer_is_wb(xfer_is_wb),
    .wdata_ok(wdata_ok), .rdata_ok(rdata_ok), .wen(wen), .sen(sen),
    .beat(beat), .xfer_done(xfer_done)
  );

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 req,
  input  logic [dcache_geom_pkg::addr_w-1:0]   addr,
  input  logic                                 wreq,
  input  logic [dcache_geom_pkg::be_w-1:0]     wbyte,
  input  logic [dcache_geom_pkg::data_w-1:0]   din,
  input  logic                                 hit,
  input  logic [dcache_geom_pkg::way_w-1:0]    hit_way,
  input  logic [dcache_geom_pkg::way_w-1:0]    victim_way,
  input  logic [dcache_geom_pkg::num_ways-1:0] dirty_vec,
  input  logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::tag_w-1:0] victim_tags,
  input  logic [dcache_geom_pkg::data_w-1:0]   cpu_rdata,
  input  logic [dcache_geom_pkg::data_w-1:0]   sdata,
  input  logic [dcache_bus_pkg::beat_cnt_w-1:0] beat,
  input  logic                                 xfer_done,
  output logic [dcache_geom_pkg::data_w-1:0]   ins,
  output logic                                 ok,
  output logic                                 miss,
  output dcache_geom_pkg::cache_addr_t         req_addr,
  output logic [dcache_geom_pkg::way_w-1:0]    cur_way,
  output logic                                 cpu_we,
  output logic [dcache_geom_pkg::be_w-1:0]     cpu_be,
  output logic                                 fill_we,
  output logic                                 tag_fill_we,
  output logic                                 dirty_set,
  output logic                                 touch,
  output logic                                 xfer_start,
  output logic                                 xfer_is_wb,
  output logic [dcache_geom_pkg::addr_w-1:0]   waddr,
  output logic [dcache_geom_pkg::addr_w-1:0]   raddr,
  output logic [dcache_geom_pkg::data_w-1:0]   fill_wdata
);

  logic [dcache_bus_pkg::st_w-1:0] st_q, st_d;
  logic                             wreq_q;
  logic [dcache_geom_pkg::data_w-1:0] din_q;
  logic [dcache_geom_pkg::way_w-1:0]  miss_way;
  dcache_geom_pkg::cache_addr_t      wb_base, rf_base;

  //////////////////////////////////////////////////
  // Request register

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      req_addr <= '0;
      wreq_q   <= 1'b0;
      cpu_be   <= '0;
      din_q    <= '0;
    end
    else if (req)
    begin
      req_addr.word <= addr;
      wreq_q        <= wreq;
      cpu_be        <= wbyte;
      din_q         <= din;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      miss_way <= '0;
    else if (st_q == dcache_bus_pkg::st_lookup)
      miss_way <= cur_way;
  end

  //////////////////////////////////////////////////
  // State machine

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      st_q <= dcache_bus_pkg::st_idle;
    else
      st_q <= st_d;
  end

  always_comb
  begin
    st_d = st_q;
    case (st_q)
      dcache_bus_pkg::st_idle:
        if (req)
          st_d = dcache_bus_pkg::st_lookup;
      dcache_bus_pkg::st_lookup:
        if (hit)
          st_d = dcache_bus_pkg::st_idle;
        else if (dirty_vec[victim_way])
          st_d = dcache_bus_pkg::st_wback;
        else
          st_d = dcache_bus_pkg::st_refill;
      dcache_bus_pkg::st_wback:
        if (xfer_done)
          st_d = dcache_bus_pkg::st_refill;
      dcache_bus_pkg::st_refill:
        if (xfer_done)
          st_d = dcache_bus_pkg::st_fill_done;
      default:
        st_d = dcache_bus_pkg::st_idle;
    endcase
  end

  assign cur_way = (st_q != dcache_bus_pkg::st_lookup) ? miss_way :
                   hit ? hit_way : victim_way;

  assign miss = (st_q == dcache_bus_pkg::st_lookup) && !hit;
  assign ok   = ((st_q == dcache_bus_pkg::st_lookup) && hit) ||
                (st_q == dcache_bus_pkg::st_fill_done);
  assign ins  = wreq_q ? din_q : cpu_rdata; // Store returns its own data

  // Stores and LRU update on completion
  assign cpu_we    = ok && wreq_q;
  assign dirty_set = cpu_we;
  assign touch     = ok;

  // Refill rewrites the current beat until it is accepted
  assign fill_we     = (st_q == dcache_bus_pkg::st_refill);
  assign tag_fill_we = fill_we && xfer_done;
  assign fill_wdata  = sdata;

  assign xfer_start = miss || ((st_q == dcache_bus_pkg::st_wback) && xfer_done);
  assign xfer_is_wb = miss && dirty_vec[victim_way];

  always_comb
  begin
    wb_base              = req_addr;
    wb_base.fld.tag      = victim_tags[cur_way];
    wb_base.fld.word_sel = '0;
    wb_base.fld.byte_sel = '0;
    rf_base              = req_addr;
    rf_base.fld.word_sel = '0;
    rf_base.fld.byte_sel = '0;
  end

  assign waddr = wb_base.word;
  assign raddr = rf_base.word;

  a_req_idle: assert property (@(posedge clk) disable iff (rst)
    req |-> (st_q == dcache_bus_pkg::st_idle));

  // No burst left running when a lookup starts
  a_lookup_beat: assert property (@(posedge clk) disable iff (rst)
    (st_q == dcache_bus_pkg::st_lookup) |-> (beat == '0));

endmodule

`default_nettype wire

/* dcache_line_xfer.sv */
`default_nettype none

module dcache_line_xfer (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 xfer_start,
  input  logic                                 xfer_is_wb,
  input  logic                                 wdata_ok,
  input  logic                                 rdata_ok,
  output logic                                 wen,
  output logic                                 sen,
  output logic [dcache_bus_pkg::beat_cnt_w-1:0] beat,
  output logic                                 xfer_done
);

  logic active;
  logic is_wb;
  logic accept;

  assign accept = is_wb ? wdata_ok : rdata_ok;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active <= 1'b0;
      is_wb  <= 1'b0;
      beat   <= '0;
    end
    else if (xfer_start)
    begin
      // A new burst may start on the last beat of the previous one
      active <= 1'b1;
      is_wb  <= xfer_is_wb;
      beat   <= '0;
    end
    else if (active && accept)
    begin
      if (beat == dcache_bus_pkg::last_beat)
      begin
        active <= 1'b0;
        beat   <= '0;
      end
      else
        beat <= beat + 1'b1;
    end
  end

  assign wen       = active && is_wb;
  assign sen       = active && !is_wb;
  assign xfer_done = active && accept && (beat == dcache_bus_pkg::last_beat);

  a_one_dir: assert property (@(posedge clk) disable iff (rst) !(wen && sen));

endmodule

`default_nettype wire

/* dcache_data_store.sv */
`default_nettype none

module dcache_data_store (
  input  logic                                   clk,
  input  logic [dcache_geom_pkg::index_w-1:0]    index,
  input  logic [dcache_geom_pkg::way_w-1:0]      way,
  input  logic [dcache_geom_pkg::word_sel_w-1:0] word_sel,
  input  logic                                   cpu_we,
  input  logic [dcache_geom_pkg::be_w-1:0]       cpu_be,
  input  logic [dcache_geom_pkg::data_w-1:0]     cpu_wdata,
  input  logic                                   fill_we,
  input  logic [dcache_geom_pkg::word_sel_w-1:0] fill_word,
  input  logic [dcache_geom_pkg::data_w-1:0]     fill_wdata,
  input  logic [dcache_geom_pkg::word_sel_w-1:0] rd_word,
  output logic [dcache_geom_pkg::data_w-1:0]     cpu_rdata,
  output logic [dcache_geom_pkg::data_w-1:0]     wb_rdata
);

  logic [dcache_geom_pkg::data_w-1:0] mem
    [dcache_geom_pkg::num_ways][dcache_geom_pkg::num_sets][dcache_geom_pkg::line_words];

  //////////////////////////////////////////////////
  // Write port, refill words or CPU bytes

  always_ff @(posedge clk)
  begin
    if (fill_we)
      mem[way][index][fill_word] <= fill_wdata;
    else if (cpu_we)
    begin
      for (int b = 0; b < dcache_geom_pkg::be_w; b++)
        if (cpu_be[b])
          mem[way][index][word_sel][8*b +: 8] <= cpu_wdata[8*b +: 8];
    end
  end

  //////////////////////////////////////////////////
  // Read ports

  assign cpu_rdata = mem[way][index][word_sel];
  assign wb_rdata  = mem[way][index][rd_word]; // Writeback stream

endmodule

`default_nettype wire

/* dcache_lru.sv */
`default_nettype none

module dcache_lru (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [dcache_geom_pkg::index_w-1:0]  index,
  input  logic [dcache_geom_pkg::num_ways-1:0] valid_vec,
  input  logic                                 touch,
  input  logic [dcache_geom_pkg::way_w-1:0]    touch_way,
  output logic [dcache_geom_pkg::way_w-1:0]    victim_way
);

  // Age 0 is most recent, age 3 is the eviction candidate
  logic [dcache_geom_pkg::way_w-1:0] age [dcache_geom_pkg::num_sets][dcache_geom_pkg::num_ways];
  logic ages_perm;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < dcache_geom_pkg::num_sets; s++)
        for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
          age[s][w] <= dcache_geom_pkg::way_w'(w);
    end
    else if (touch)
    begin
      for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
      begin
        if (dcache_geom_pkg::way_w'(w) == touch_way)
          age[index][w] <= '0;
        else if (age[index][w] < age[index][touch_way])
          age[index][w] <= age[index][w] + 1'b1;
      end
    end
  end

  always_comb
  begin
    victim_way = '0;
    for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
      if (age[index][w] == dcache_geom_pkg::way_w'(dcache_geom_pkg::num_ways - 1))
        victim_way = dcache_geom_pkg::way_w'(w);
    for (int w = dcache_geom_pkg::num_ways - 1; w >= 0; w--) // Lowest invalid way wins
      if (!valid_vec[w])
        victim_way = dcache_geom_pkg::way_w'(w);
  end

  always_comb
  begin
    logic [dcache_geom_pkg::num_ways-1:0] seen;
    ages_perm = 1'b1;
    for (int s = 0; s < dcache_geom_pkg::num_sets; s++)
    begin
      seen = '0;
      for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
        seen[age[s][w]] = 1'b1;
      if (seen != '1)
        ages_perm = 1'b0;
    end
  end

  a_ages_perm: assert property (@(posedge clk) disable iff (rst) ages_perm);

endmodule

`default_nettype wire

/* dcache_tag_store.sv */
`default_nettype none

module dcache_tag_store (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [dcache_geom_pkg::index_w-1:0] index,
  input  logic [dcache_geom_pkg::tag_w-1:0]   tag,
  input  logic [dcache_geom_pkg::way_w-1:0]   fill_way,
  input  logic                                fill_we,
  input  logic [dcache_geom_pkg::way_w-1:0]   dirty_way,
  input  logic                                dirty_set,
  output logic                                hit,
  output logic [dcache_geom_pkg::way_w-1:0]   hit_way,
  output logic [dcache_geom_pkg::num_ways-1:0] valid_vec,
  output logic [dcache_geom_pkg::num_ways-1:0] dirty_vec,
  output logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::tag_w-1:0] victim_tags
);

  logic [dcache_geom_pkg::tag_w-1:0] tag_mem [dcache_geom_pkg::num_ways][dcache_geom_pkg::num_sets];
  logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::num_sets-1:0] valid_q;
  logic [dcache_geom_pkg::num_ways-1:0][dcache_geom_pkg::num_sets-1:0] dirty_q;
  logic [dcache_geom_pkg::num_ways-1:0] hit_vec;

  always_ff @(posedge clk)
  begin
    if (fill_we)
      tag_mem[fill_way][index] <= tag;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      if (fill_we)
      begin
        valid_q[fill_way][index] <= 1'b1;
        dirty_q[fill_way][index] <= 1'b0; // Fresh line is clean
      end
      if (dirty_set)
        dirty_q[dirty_way][index] <= 1'b1;
    end
  end

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
    begin
      valid_vec[w]   = valid_q[w][index];
      dirty_vec[w]   = dirty_q[w][index];
      victim_tags[w] = tag_mem[w][index];
      hit_vec[w]     = valid_q[w][index] && (tag_mem[w][index] == tag);
      if (hit_vec[w])
        hit_way = dcache_geom_pkg::way_w'(w);
    end
  end

  assign hit = |hit_vec;

  // A line is never filled twice into one set
  a_single_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

`default_nettype wire

/* dcache_bus_pkg.sv */
`default_nettype none

package dcache_bus_pkg;

  // Burst beats, one per line word
  localparam int                  beat_cnt_w = 4;
  localparam logic [beat_cnt_w-1:0] last_beat = 4'd15;

  localparam int st_w = 3;

  localparam logic [st_w-1:0] st_idle      = 3'd0;
  localparam logic [st_w-1:0] st_lookup    = 3'd1;
  localparam logic [st_w-1:0] st_wback     = 3'd2;
  localparam logic [st_w-1:0] st_refill    = 3'd3;
  localparam logic [st_w-1:0] st_fill_done = 3'd4;

endpackage

`default_nettype wire

/* dcache_geom_pkg.sv */
`default_nettype none

package dcache_geom_pkg;

  localparam int num_ways   = 4;
  localparam int way_w      = 2;
  localparam int num_sets   = 16;
  localparam int index_w    = 4;
  localparam int line_words = 16;
  localparam int word_sel_w = 4;
  localparam int tag_w      = 22;
  localparam int addr_w     = 32;
  localparam int data_w     = 32;
  localparam int be_w       = 4;

  // CPU byte address, seen whole or split into its cache fields
  typedef union packed {
    logic [addr_w-1:0] word;
    struct packed {
      logic [tag_w-1:0]      tag;
      logic [index_w-1:0]    index;
      logic [word_sel_w-1:0] word_sel;
      logic [1:0]            byte_sel;
    } fld;
  } cache_addr_t;

endpackage

`default_nettype wire
